//--- hw/mem_bus_config.svh
// Bus, line and memory sizing for the memory node
`ifndef MEM_BUS_CONFIG_SVH
`define MEM_BUS_CONFIG_SVH

// Bus beat and address widths
`define MEM_BUS_DATA_W 32
`define MEM_BUS_ADDR_W 16

// Bytes per memory line, also bytes per read reply
`define MEM_LINE_BYTES 16

// Memory depth in lines and access time in cycles
`define MEM_LINES   256
`define MEM_LATENCY 4

`endif

//--- hw/mem_bus_pkg.sv
// Shared types: bus beat, destination lines, memory command, controller states

`include "mem_bus_config.svh"

package mem_bus_pkg;

   // Direction of a bus transfer
   typedef enum logic
   {
      BUS_RD = 1'b0,
      BUS_WR = 1'b1
   } bus_rw_e;

   // One-hot unit select
   typedef struct packed
   {
      logic ic;
      logic dc;
      logic dma;
   } dest_t;

   // One bus cycle
   typedef struct packed
   {
      logic                         strobe;
      bus_rw_e                      rw;
      logic [`MEM_BUS_ADDR_W-1:0]   a;
      logic [11:0]                  size;
      dest_t                        src;
      logic [`MEM_BUS_DATA_W-1:0]   d;
   } bus_beat_t;

   // Line-wide memory bank command
   typedef struct packed
   {
      logic                           en;
      logic                           wr;
      logic [$clog2(`MEM_LINES)-1:0]  line;
      logic [`MEM_LINE_BYTES*8-1:0]   wdata;
      logic [`MEM_LINE_BYTES-1:0]     wmask;
   } mem_cmd_t;

   typedef enum logic [2:0]
   {
      ST_IDLE = 3'd0,
      ST_SLV  = 3'd1,
      ST_MEM  = 3'd2,
      ST_BR   = 3'd3,
      ST_MSTR = 3'd4
   } ctrl_state_e;

endpackage

//--- hw/mem_byte_shifter.sv
// Byte shifter for line data and its byte mask
`timescale 1ns/1ps
`include "mem_bus_config.svh"

module mem_byte_shifter
(
   input  logic [`MEM_LINE_BYTES*8-1:0] din,
   input  logic [`MEM_LINE_BYTES-1:0]   mask_in,
   input  logic [3:0]                   amount,
   output logic [`MEM_LINE_BYTES*8-1:0] dout,
   output logic [`MEM_LINE_BYTES-1:0]   mask_out
);

   logic [`MEM_LINE_BYTES*8-1:0] d_shift [16];
   logic [`MEM_LINE_BYTES-1:0]   m_shift [16];
   logic [`MEM_LINE_BYTES*8-1:0] d_grp [4];
   logic [`MEM_LINE_BYTES-1:0]   m_grp [4];

   always_comb
   begin
      // All sixteen byte shifts, zero filled
      for (int i = 0; i < 16; i++)
      begin
         d_shift[i] = din << (8 * i);
         m_shift[i] = mask_in << i;
      end
      // First level picks within each group of four by amount[1:0]
      for (int g = 0; g < 4; g++)
      begin
         d_grp[g] = d_shift[4 * g + int'(amount[1:0])];
         m_grp[g] = m_shift[4 * g + int'(amount[1:0])];
      end
      // Second level picks the group
      dout     = d_grp[amount[3:2]];
      mask_out = m_grp[amount[3:2]];
   end

endmodule

//--- hw/mem_ctrl_fsm.sv
// Controller FSM with beat counter and shifting memory access timer
`timescale 1ns/1ps
`include "mem_bus_config.svh"

module mem_ctrl_fsm
(
   input  logic                      bus_clk,
   input  logic                      arst_n,
   input  logic                      req_strobe,
   input  mem_bus_pkg::bus_rw_e      req_rw,
   input  logic                      bg,
   input  logic                      ack_in,
   output mem_bus_pkg::ctrl_state_e  state,
   output logic [1:0]                beat_idx,
   output logic                      mem_issue,
   output logic                      capture,
   output logic                      br,
   output logic                      ack_out,
   output logic                      send
);

   import mem_bus_pkg::*;

   ctrl_state_e             state_q;
   ctrl_state_e             state_d;
   logic [`MEM_LATENCY-1:0] timer_q;
   logic [1:0]              beat_q;
   logic                    sent_all_q;
   logic                    ack_q;
   logic                    wr_accept;
   logic                    timer_done;
   logic                    last_beat;

   assign wr_accept  = req_strobe && (req_rw == BUS_WR) &&
                       (state_q == ST_IDLE || state_q == ST_SLV);
   assign timer_done = timer_q[`MEM_LATENCY-1];
   assign last_beat  = (beat_q == 2'd3);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE : if (req_strobe) state_d = (req_rw == BUS_WR) ? ST_SLV : ST_MEM;
         ST_SLV  : if (wr_accept && last_beat) state_d = ST_MEM;
         ST_MEM  : if (timer_done) state_d = (req_rw == BUS_WR) ? ST_IDLE : ST_BR;
         ST_BR   : if (bg) state_d = ST_MSTR;
         ST_MSTR : if (sent_all_q && ack_in) state_d = ST_IDLE;
         default : state_d = ST_IDLE;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // State, beat counter, timer
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state_q    <= ST_IDLE;
         beat_q     <= 2'd0;
         timer_q    <= `MEM_LATENCY'(1);
         sent_all_q <= 1'b0;
         ack_q      <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (wr_accept || send)
            beat_q <= beat_q + 2'd1;
         // One bit walks up per cycle spent in ST_MEM
         timer_q    <= (state_q == ST_MEM) ? {timer_q[`MEM_LATENCY-2:0], 1'b0}
                                           : `MEM_LATENCY'(1);
         sent_all_q <= (state_q == ST_MSTR) && (sent_all_q || (send && last_beat));
         ack_q      <= (state_q == ST_MEM) && timer_done && (req_rw == BUS_WR);
      end
   end

   assign state     = state_q;
   assign beat_idx  = beat_q;
   assign mem_issue = (state_q == ST_MEM) && timer_q[0];
   assign capture   = (state_q == ST_MEM) && timer_done && (req_rw == BUS_RD);
   assign br        = (state_q == ST_BR);
   assign ack_out   = ack_q;
   assign send      = (state_q == ST_MSTR) && !sent_all_q;

endmodule

//--- hw/mem_line_buffers.sv
// Write gather buffer, read line buffer and outgoing beat select
`timescale 1ns/1ps
`include "mem_bus_config.svh"

module mem_line_buffers
(
   input  logic                          bus_clk,
   input  logic                          arst_n,
   input  logic                          wr_beat,
   input  logic [1:0]                    beat_idx,
   input  logic [`MEM_BUS_DATA_W-1:0]    beat_data,
   input  logic                          capture,
   input  logic [`MEM_LINE_BYTES*8-1:0]  mem_rdata,
   output logic [`MEM_LINE_BYTES*8-1:0]  wr_line,
   output logic [`MEM_BUS_DATA_W-1:0]    rd_beat
);

   logic [`MEM_LINE_BYTES*8-1:0] wr_buf_q;
   logic [`MEM_LINE_BYTES*8-1:0] rd_buf_q;

   // Beat k fills bytes 4k+3 down to 4k
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_buf_q <= '0;
      end
      else if (wr_beat)
      begin
         wr_buf_q[beat_idx*`MEM_BUS_DATA_W +: `MEM_BUS_DATA_W] <= beat_data;
      end
   end

   // Line from the memory bank, held for the reply beats
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rd_buf_q <= '0;
      end
      else if (capture)
      begin
         rd_buf_q <= mem_rdata;
      end
   end

   assign wr_line = wr_buf_q;

   // Outgoing beat mux
   always_comb
   begin
      case (beat_idx)
         2'd0    : rd_beat = rd_buf_q[0*`MEM_BUS_DATA_W +: `MEM_BUS_DATA_W];
         2'd1    : rd_beat = rd_buf_q[1*`MEM_BUS_DATA_W +: `MEM_BUS_DATA_W];
         2'd2    : rd_beat = rd_buf_q[2*`MEM_BUS_DATA_W +: `MEM_BUS_DATA_W];
         default : rd_beat = rd_buf_q[3*`MEM_BUS_DATA_W +: `MEM_BUS_DATA_W];
      endcase
   end

endmodule

//--- hw/mem_bus_controller.sv
// Memory bus controller: request registers, command build, reply beats
`timescale 1ns/1ps
`include "mem_bus_config.svh"

module mem_bus_controller
(
   input  logic                          bus_clk,
   input  logic                          arst_n,
   input  mem_bus_pkg::bus_beat_t        bus_in,
   input  logic                          mem_sel,
   input  logic                          bg,
   input  logic                          ack_in,
   output mem_bus_pkg::bus_beat_t        bus_out,
   output logic                          bus_drive,
   output logic                          br,
   output logic                          ack_out,
   output mem_bus_pkg::dest_t            dest_out,
   output mem_bus_pkg::mem_cmd_t         mem_cmd,
   input  logic [`MEM_LINE_BYTES*8-1:0]  mem_rdata
);

   import mem_bus_pkg::*;

   localparam int LINE_W = `MEM_LINE_BYTES * 8;

   ctrl_state_e                 state;
   bus_rw_e                     rw_q;
   bus_rw_e                     req_rw;
   dest_t                       src_q;
   logic [`MEM_BUS_ADDR_W-1:0]  a_q;
   logic [11:0]                 size_q;
   logic                        req_strobe;
   logic                        wr_beat;
   logic                        first_beat;
   logic [1:0]                  beat_idx;
   logic                        mem_issue;
   logic                        capture;
   logic                        send;
   logic [LINE_W-1:0]           wr_line;
   logic [LINE_W-1:0]           wr_shifted;
   logic [`MEM_BUS_DATA_W-1:0]  rd_beat;
   logic [`MEM_LINE_BYTES-1:0]  size_mask;
   logic [`MEM_LINE_BYTES-1:0]  wmask;

   assign req_strobe = bus_in.strobe && mem_sel;
   // Live direction while idle, recorded one for the rest of the transfer
   assign req_rw     = (state == ST_IDLE) ? bus_in.rw : rw_q;
   assign first_beat = (state == ST_IDLE) && req_strobe;
   assign wr_beat    = req_strobe && (req_rw == BUS_WR) &&
                       (state == ST_IDLE || state == ST_SLV);

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rw_q  <= BUS_RD;
         src_q <= '0;
      end
      else if (first_beat)
      begin
         rw_q  <= bus_in.rw;
         src_q <= bus_in.src;
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (first_beat)
      begin
         a_q    <= bus_in.a;
         size_q <= bus_in.size;
      end
   end

   mem_ctrl_fsm i_fsm (
      .bus_clk, .arst_n, .req_strobe, .req_rw, .bg, .ack_in, .state,
      .beat_idx, .mem_issue, .capture, .br, .ack_out, .send
   );

   mem_line_buffers i_buffers (
      .bus_clk, .arst_n, .wr_beat, .beat_idx, .beat_data(bus_in.d),
      .capture, .mem_rdata, .wr_line, .rd_beat
   );

   // Low size bytes of the gathered line
   assign size_mask = (size_q >= 12'(`MEM_LINE_BYTES)) ? '1 : ~('1 << size_q[4:0]);

   mem_byte_shifter i_shifter (
      .din(wr_line), .mask_in(size_mask), .amount(a_q[3:0]),
      .dout(wr_shifted), .mask_out(wmask)
   );

   always_comb
   begin
      mem_cmd.en    = mem_issue;
      mem_cmd.wr    = mem_issue && (rw_q == BUS_WR);
      mem_cmd.line  = a_q[4 +: $clog2(`MEM_LINES)];
      mem_cmd.wdata = wr_shifted;
      mem_cmd.wmask = wmask;
   end

   // Reply beats, always a full line
   always_comb
   begin
      bus_out = '0;
      if (send)
      begin
         bus_out.strobe = 1'b1;
         bus_out.rw     = BUS_WR;
         bus_out.a      = {a_q[`MEM_BUS_ADDR_W-1:4], 4'h0};
         bus_out.size   = 12'(`MEM_LINE_BYTES);
         bus_out.d      = rd_beat;
      end
   end

   assign bus_drive = send;
   assign dest_out  = send ? src_q : '0;

endmodule

//--- hw/mem_array.sv
// Line-wide memory bank with byte-masked writes and registered read
`timescale 1ns/1ps
`include "mem_bus_config.svh"

module mem_array
(
   input  logic                          bus_clk,
   input  mem_bus_pkg::mem_cmd_t         mem_cmd,
   output logic [`MEM_LINE_BYTES*8-1:0]  rdata
);

   import mem_bus_pkg::*;

   logic [`MEM_LINE_BYTES*8-1:0] mem_q [`MEM_LINES];

   ////////////////////////////////////////////////////////////////////////////
   // Write path, only bytes with their mask bit set
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge bus_clk)
   begin
      if (mem_cmd.en && mem_cmd.wr)
      begin
         for (int b = 0; b < `MEM_LINE_BYTES; b++)
         begin
            if (mem_cmd.wmask[b])
               mem_q[mem_cmd.line][8*b +: 8] <= mem_cmd.wdata[8*b +: 8];
         end
      end
   end

   // Read data one cycle after the read command
   always_ff @(posedge bus_clk)
   begin
      if (mem_cmd.en && !mem_cmd.wr)
      begin
         rdata <= mem_q[mem_cmd.line];
      end
   end

endmodule

//--- hw/mem_node.sv
// Memory node top: bus controller and memory bank
`timescale 1ns/1ps
`include "mem_bus_config.svh"

module mem_node
(
   input  logic                    bus_clk,
   input  logic                    arst_n,
   input  mem_bus_pkg::bus_beat_t  bus_in,
   input  logic                    mem_sel,
   input  logic                    bg,
   input  logic                    ack_in,
   output mem_bus_pkg::bus_beat_t  bus_out,
   output logic                    bus_drive,
   output logic                    br,
   output logic                    ack_out,
   output mem_bus_pkg::dest_t      dest_out
);

   import mem_bus_pkg::*;

   mem_cmd_t                      mem_cmd;
   logic [`MEM_LINE_BYTES*8-1:0]  mem_rdata;

   mem_bus_controller i_ctrl (
      .bus_clk, .arst_n, .bus_in, .mem_sel, .bg, .ack_in,
      .bus_out, .bus_drive, .br, .ack_out, .dest_out,
      .mem_cmd, .mem_rdata
   );

   mem_array i_mem (
      .bus_clk,
      .mem_cmd,
      .rdata(mem_rdata)
   );

endmodule

//--- verif/mem_bus_assertions.sv
// Protocol assertions for the memory bus controller
`timescale 1ns/1ps

module mem_bus_assertions
(
   input logic                bus_clk,
   input logic                arst_n,
   input logic                br,
   input logic                bus_drive,
   input logic                ack_out,
   input mem_bus_pkg::dest_t  dest_out,
   input logic                strobe
);

   // Read out by the testbench at the end of the run
   int fail_count = 0;

   // Requesting the bus and driving it never overlap
   a_br_vs_drive : assert property (
      @(posedge bus_clk) disable iff (!arst_n) !(br && bus_drive))
   else
   begin
      fail_count++;
      $error("br and bus_drive high in the same cycle");
   end

   a_dest_onehot : assert property (
      @(posedge bus_clk) disable iff (!arst_n) $onehot0(dest_out))
   else
   begin
      fail_count++;
      $error("dest_out has more than one bit set");
   end

   // Write acknowledge lasts one cycle
   a_ack_pulse : assert property (
      @(posedge bus_clk) disable iff (!arst_n) ack_out |=> !ack_out)
   else
   begin
      fail_count++;
      $error("ack_out high for more than one cycle");
   end

   a_reset_quiet : assert property (
      @(posedge bus_clk) $rose(arst_n) |->
         (!br && !ack_out && !bus_drive && (dest_out == '0) && !strobe))
   else
   begin
      fail_count++;
      $error("outputs not low when reset is released");
   end

endmodule

//--- verif/mem_bus_tb.sv
// Memory node testbench with transfer table, reference memory and timing checks
`timescale 1ns/1ps
`include "mem_bus_config.svh"

module mem_bus_tb;

   import mem_bus_pkg::*;

   localparam int NUM_ROWS     = 10;
   localparam int RESET_CYCLES = 5;
   localparam int ACK_DELAY    = 3;
   localparam int LINE_B       = `MEM_LINE_BYTES;
   localparam dest_t SRC_IC    = 3'b100;
   localparam dest_t SRC_DC    = 3'b010;
   localparam dest_t SRC_DMA   = 3'b001;

   // One table row with a full transfer and its grant delay
   typedef struct packed
   {
      bus_rw_e                     rw;
      logic [`MEM_BUS_ADDR_W-1:0]  a;
      logic [11:0]                 size;
      dest_t                       src;
      logic [LINE_B*8-1:0]         data;
      logic [7:0]                  bg_delay;
   } row_t;

   logic        bus_clk = 1'b0;
   logic        arst_n;
   bus_beat_t   bus_in;
   logic        mem_sel;
   logic        bg;
   logic        ack_in;
   bus_beat_t   bus_out;
   logic        bus_drive;
   logic        br;
   logic        ack_out;
   dest_t       dest_out;

   row_t        rows [NUM_ROWS];
   logic [7:0]  ref_mem [`MEM_LINES*LINE_B];
   integer      seed = 32'h100c_f75c;
   int          errors = 0;
   int          assert_fails;
   int          cycle_count = 0;
   int          cycle_limit = 0;

   always #4 bus_clk = ~bus_clk;

   mem_node i_mem_node (
      .bus_clk, .arst_n, .bus_in, .mem_sel, .bg, .ack_in,
      .bus_out, .bus_drive, .br, .ack_out, .dest_out
   );

   bind mem_bus_controller mem_bus_assertions i_assertions (
      .bus_clk(bus_clk), .arst_n(arst_n), .br(br), .bus_drive(bus_drive),
      .ack_out(ack_out), .dest_out(dest_out), .strobe(bus_out.strobe)
   );

   // Run limit
   always @(posedge bus_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: run still busy after %0d cycles", cycle_count);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                  input logic [127:0] act_v);
      errors++;
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
   endtask

   function automatic row_t make_row(input bus_rw_e rw, input logic [15:0] a,
                                     input int size, input dest_t src, input int bg_delay);
      row_t r;
      r.rw       = rw;
      r.a        = a;
      r.size     = 12'(size);
      r.src      = src;
      r.data     = {$random(seed), $random(seed), $random(seed), $random(seed)};
      r.bg_delay = 8'(bg_delay);
      return r;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Write of four beats followed by the acknowledge window
   ////////////////////////////////////////////////////////////////////////////
   task automatic write_transfer(input row_t r);
      int        line;
      int        off;
      logic      exp_bit;
      bus_beat_t beat;
      line = int'(r.a[11:4]);
      off  = int'(r.a[3:0]);
      for (int k = 0; k < 4; k++)
      begin
         beat = '{strobe: 1'b1, rw: BUS_WR, a: r.a, size: r.size, src: r.src,
                  d: r.data[32*k +: 32]};
         @(posedge bus_clk);
         bus_in  <= beat;
         mem_sel <= 1'b1;
         @(negedge bus_clk);
         if (ack_out !== 1'b0) report_mismatch("ack_out", 128'(0), 128'(ack_out));
      end
      @(posedge bus_clk);
      bus_in  <= '0;
      mem_sel <= 1'b0;
      for (int b = 0; b < int'(r.size); b++)
         ref_mem[line*LINE_B + off + b] = r.data[8*b +: 8];
      // Pulse expected MEM_LATENCY+1 cycles after the fourth beat
      for (int i = 1; i <= `MEM_LATENCY + 2; i++)
      begin
         exp_bit = (i == `MEM_LATENCY + 1);
         @(negedge bus_clk);
         if (ack_out !== exp_bit) report_mismatch("ack_out", 128'(exp_bit), 128'(ack_out));
         if (br !== 1'b0) report_mismatch("br", 128'(0), 128'(br));
         if (bus_drive !== 1'b0) report_mismatch("bus_drive", 128'(0), 128'(bus_drive));
         if (dest_out !== '0) report_mismatch("dest_out", 128'(0), 128'(dest_out));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Read with request, bus grant, reply beats and acknowledge
   ////////////////////////////////////////////////////////////////////////////
   task automatic read_transfer(input row_t r);
      int                         line;
      logic                       exp_bit;
      logic [`MEM_BUS_DATA_W-1:0] exp_d;
      bus_beat_t                  beat;
      line = int'(r.a[11:4]);
      beat = '{strobe: 1'b1, rw: BUS_RD, a: r.a, size: r.size, src: r.src, d: '0};
      @(posedge bus_clk);
      bus_in  <= beat;
      mem_sel <= 1'b1;
      @(posedge bus_clk);
      bus_in  <= '0;
      mem_sel <= 1'b0;
      for (int i = 1; i <= `MEM_LATENCY + 1; i++)
      begin
         exp_bit = (i == `MEM_LATENCY + 1);
         @(negedge bus_clk);
         if (br !== exp_bit) report_mismatch("br", 128'(exp_bit), 128'(br));
         if (ack_out !== 1'b0) report_mismatch("ack_out", 128'(0), 128'(ack_out));
      end
      // br must stay up while the grant is held back
      for (int i = 0; i <= int'(r.bg_delay); i++)
      begin
         if (i == int'(r.bg_delay))
         begin
            @(posedge bus_clk);
            bg <= 1'b1;
         end
         @(negedge bus_clk);
         if (br !== 1'b1) report_mismatch("br", 128'(1), 128'(br));
         if (bus_drive !== 1'b0) report_mismatch("bus_drive", 128'(0), 128'(bus_drive));
         if (dest_out !== '0) report_mismatch("dest_out", 128'(0), 128'(dest_out));
      end
      @(posedge bus_clk);
      bg <= 1'b0;
      // Four consecutive beats from the cycle after the grant
      for (int k = 0; k < 4; k++)
      begin
         for (int j = 0; j < 4; j++)
            exp_d[8*j +: 8] = ref_mem[line*LINE_B + 4*k + j];
         @(negedge bus_clk);
         if (bus_out.strobe !== 1'b1)
            report_mismatch("bus_out.strobe", 128'(1), 128'(bus_out.strobe));
         if (bus_out.d !== exp_d) report_mismatch("bus_out.d", 128'(exp_d), 128'(bus_out.d));
         if (bus_out.rw !== BUS_WR) report_mismatch("bus_out.rw", 128'(BUS_WR), 128'(bus_out.rw));
         if (bus_out.size !== 12'(LINE_B))
            report_mismatch("bus_out.size", 128'(LINE_B), 128'(bus_out.size));
         if (dest_out !== r.src) report_mismatch("dest_out", 128'(r.src), 128'(dest_out));
         if (bus_drive !== 1'b1) report_mismatch("bus_drive", 128'(1), 128'(bus_drive));
         if (br !== 0) report_mismatch("br", 128'(0), 128'(br));
      end
      // Stray request during the late acknowledge must be ignored
      @(posedge bus_clk);
      bus_in  <= beat;
      mem_sel <= 1'b1;
      for (int i = 0; i < ACK_DELAY; i++)
      begin
         @(negedge bus_clk);
         if (bus_drive !== 1'b0) report_mismatch("bus_drive", 128'(0), 128'(bus_drive));
         if (dest_out !== '0) report_mismatch("dest_out", 128'(0), 128'(dest_out));
         if (i_mem_node.i_ctrl.state !== ST_MSTR)
            report_mismatch("state", 128'(ST_MSTR), 128'(i_mem_node.i_ctrl.state));
      end
      @(posedge bus_clk);
      ack_in  <= 1'b1;
      bus_in  <= '0;
      mem_sel <= 1'b0;
      @(posedge bus_clk);
      ack_in <= 1'b0;
      @(negedge bus_clk);
      if (i_mem_node.i_ctrl.state !== ST_IDLE)
         report_mismatch("state", 128'(ST_IDLE), 128'(i_mem_node.i_ctrl.state));
   endtask

   initial
   begin
      arst_n  = 1'b0;
      bus_in  = '0;
      mem_sel = 1'b0;
      bg      = 1'b0;
      ack_in  = 1'b0;

      // Full lines first so every read hits known data
      rows[0] = make_row(BUS_WR, 16'h0030, 16, SRC_DC, 0);
      rows[1] = make_row(BUS_RD, 16'h0030, 16, SRC_IC, 0);
      rows[2] = make_row(BUS_WR, 16'h0030, 8, SRC_DMA, 0);
      rows[3] = make_row(BUS_WR, 16'h0035, 1, SRC_IC, 0);
      rows[4] = make_row(BUS_WR, 16'h003A, 2, SRC_DC, 0);
      rows[5] = make_row(BUS_WR, 16'h003C, 4, SRC_DMA, 0);
      rows[6] = make_row(BUS_RD, 16'h0030, 16, SRC_DMA, 3);
      rows[7] = make_row(BUS_WR, 16'h07F0, 16, SRC_IC, 0);
      rows[8] = make_row(BUS_RD, 16'h07F4, 16, SRC_DC, 5);
      rows[9] = make_row(BUS_RD, 16'h0030, 16, SRC_IC, 1);

      cycle_limit = RESET_CYCLES + 2;
      for (int n = 0; n < NUM_ROWS; n++)
         cycle_limit += 4 + `MEM_LATENCY + int'(rows[n].bg_delay) + 10;

      repeat (RESET_CYCLES)
      begin
         @(negedge bus_clk);
         if (br !== 1'b0) report_mismatch("br", 128'(0), 128'(br));
         if (ack_out !== 1'b0) report_mismatch("ack_out", 128'(0), 128'(ack_out));
         if (bus_drive !== 1'b0) report_mismatch("bus_drive", 128'(0), 128'(bus_drive));
         if (dest_out !== '0) report_mismatch("dest_out", 128'(0), 128'(dest_out));
         if (bus_out.strobe !== 1'b0)
            report_mismatch("bus_out.strobe", 128'(0), 128'(bus_out.strobe));
      end
      @(posedge bus_clk);
      arst_n <= 1'b1;

      for (int n = 0; n < NUM_ROWS; n++)
      begin
         if (rows[n].rw == BUS_WR)
            write_transfer(rows[n]);
         else
            read_transfer(rows[n]);
      end

      assert_fails = i_mem_node.i_ctrl.i_assertions.fail_count;
      $display("Errors: %0d check, %0d assertion", errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- all.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/mem_byte_shifter.sv
hw/mem_ctrl_fsm.sv
hw/mem_line_buffers.sv
hw/mem_bus_controller.sv
hw/mem_array.sv
hw/mem_node.sv
verif/mem_bus_assertions.sv
verif/mem_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory node testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_bus_tb -f all.f -o mem_bus_sim
./obj_dir/mem_bus_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log
then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
